// File: design/controlPkg.sv
package controlPkg;

    typedef logic [5:0] fieldT;            // Opcode or funct field
    typedef logic [2:0] sizeSelT;          // Memory access size select

    localparam fieldT opRType = 6'h00;
    localparam fieldT opJ     = 6'h02;
    localparam fieldT opJal   = 6'h03;
    localparam fieldT opBeq   = 6'h04;
    localparam fieldT opBne   = 6'h05;
    localparam fieldT opAddi  = 6'h08;
    localparam fieldT opAddiu = 6'h09;
    localparam fieldT opSlti  = 6'h0a;
    localparam fieldT opLw    = 6'h23;
    localparam fieldT opSw    = 6'h2b;

    localparam fieldT functAdd = 6'h20;
    localparam fieldT functSub = 6'h22;
    localparam fieldT functAnd = 6'h24;
    localparam fieldT functOr  = 6'h25;
    localparam fieldT functSlt = 6'h2a;

    localparam sizeSelT sizeWord      = 3'b100;
    localparam sizeSelT sizeException = 3'b110;

    typedef enum logic [2:0] {
        clsAluReg, clsAluImm, clsBranch, clsLoad, clsStore, clsJump, clsJal, clsInvalid
    } instrClassT;

    // ALU operation codes as seen by the datapath ALU
    typedef enum logic [4:0] {
        aluPass     = 5'b00000,
        aluAddOvf   = 5'b00001,
        aluSub      = 5'b00010,
        aluAnd      = 5'b00011,
        aluCmp      = 5'b00111,
        aluOr       = 5'b01000,
        aluAddNoOvf = 5'b01011,
        aluNe       = 5'b01110,
        aluEq       = 5'b01111
    } aluOpT;

    typedef enum logic [1:0] {causeNone, causeInvalidOp, causeOverflow} faultCauseT;
    typedef enum logic [1:0] {phaseIdle, phaseSaveEpc, phaseVector} faultPhaseT;

    typedef enum logic [1:0] {destRt, destRd, destRa, destStack} regDestT;
    typedef enum logic [2:0] {
        m2rAlu        = 3'b000,
        m2rMemory     = 3'b001,
        m2rStackInit  = 3'b010,
        m2rReturnAddr = 3'b100
    } memToRegT;
    typedef enum logic [1:0] {srcAPc, srcARegA} aluSrcAT;
    typedef enum logic [2:0] {srcBRegB, srcBFour, srcBImmediate, srcBBranchOffset} aluSrcBT;
    typedef enum logic [2:0] {pcJumpTarget, pcAluResult, pcAluOut, pcVector} pcSourceT;
    typedef enum logic [2:0] {addrNormal, addrInvalidVec, addrOverflowVec} addrSelectT;

    typedef struct packed {
        logic       pcWrite;
        logic       pcWriteCond;
        logic       iorD;
        logic       memWrite;
        logic       irWrite;
        logic       epcWrite;
        logic       regWrite;
        regDestT    regDest;
        memToRegT   memToReg;
        aluSrcAT    aluSrcA;
        aluSrcBT    aluSrcB;
        pcSourceT   pcSource;
        addrSelectT addrSelect;
        aluOpT      aluOp;
        sizeSelT    sizeSel;
    } controlWordT;

    typedef struct packed {
        instrClassT instrClass;
        aluOpT      aluOp;
    } decodeT;

    typedef struct packed {
        logic decodeNow;      // Sequencer sits in decode
        logic overflowWatch;  // Execute cycle that may overflow
    } seqStatusT;

endpackage

// File: design/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer import controlPkg::*;
#(
    parameter int FetchWait = 2
)
(
    input  logic        clk,
    input  logic        reset,
    input  decodeT      decoded,
    input  faultPhaseT  phase,
    input  faultCauseT  cause,
    output seqStatusT   seqStatus,
    output controlWordT control
);

    localparam int WaitWidth = $clog2(FetchWait + 2);
    localparam logic [WaitWidth-1:0] FetchCount = WaitWidth'(FetchWait - 1);
    localparam logic [WaitWidth-1:0] TwoCycles  = WaitWidth'(1);

    typedef enum logic [3:0] {
        stResetInit, stFetchWait, stFetchLoad, stDecode,
        stExecute, stWriteRd, stWriteRt,
        stBranchTarget, stBranchCompare, stBranchCommit,
        stMemAddr, stMemRead, stLoadWrite, stStoreWrite,
        stJump, stJal
    } stateT;

    stateT                state;
    logic [WaitWidth-1:0] waitCount;  // Remaining cycles of a multi-cycle state

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= stResetInit;
            waitCount <= TwoCycles;
        end
        else if (phase != phaseIdle)
        begin
            state     <= stFetchWait;  // Park here until the fault is done
            waitCount <= FetchCount;
        end
        else
        begin
            case (state)
                stResetInit, stFetchWait, stMemRead, stLoadWrite, stJal:
                begin
                    if (waitCount != '0)
                        waitCount <= waitCount - 1'b1;
                    else if (state == stResetInit || state == stLoadWrite || state == stJal)
                    begin
                        state     <= stFetchWait;
                        waitCount <= FetchCount;
                    end
                    else if (state == stFetchWait)
                        state <= stFetchLoad;
                    else
                    begin
                        state     <= stLoadWrite;
                        waitCount <= TwoCycles;
                    end
                end
                stFetchLoad: state <= stDecode;
                stDecode:
                begin
                    waitCount <= TwoCycles;
                    case (decoded.instrClass)
                        clsAluReg, clsAluImm: state <= stExecute;
                        clsBranch:            state <= stBranchTarget;
                        clsLoad, clsStore:    state <= stMemAddr;
                        clsJump:              state <= stJump;
                        clsJal:               state <= stJal;
                        default:
                        begin
                            state     <= stFetchWait;  // Monitor raises the fault
                            waitCount <= FetchCount;
                        end
                    endcase
                end
                stExecute: state <= (decoded.instrClass == clsAluReg) ? stWriteRd : stWriteRt;
                stBranchTarget:  state <= stBranchCompare;
                stBranchCompare: state <= stBranchCommit;
                stMemAddr:
                begin
                    state     <= (decoded.instrClass == clsLoad) ? stMemRead : stStoreWrite;
                    waitCount <= TwoCycles;
                end
                default:
                begin
                    state     <= stFetchWait;
                    waitCount <= FetchCount;
                end
            endcase
        end
    end

    assign seqStatus.decodeNow     = (state == stDecode);
    assign seqStatus.overflowWatch = (state == stExecute) || (state == stMemAddr);

    always_comb
    begin
        control.pcWrite     = 1'b0;
        control.pcWriteCond = 1'b0;
        control.iorD        = 1'b0;
        control.memWrite    = 1'b0;
        control.irWrite     = 1'b0;
        control.epcWrite    = 1'b0;
        control.regWrite    = 1'b0;
        control.regDest     = destRt;
        control.memToReg    = m2rAlu;
        control.aluSrcA     = srcAPc;
        control.aluSrcB     = srcBRegB;
        control.pcSource    = pcAluOut;
        control.addrSelect  = addrNormal;
        control.aluOp       = aluPass;
        control.sizeSel     = sizeWord;

        if (phase == phaseSaveEpc)
        begin
            control.epcWrite = 1'b1;
            control.aluSrcB  = srcBFour;  // PC minus 4 back to the faulting word
            control.aluOp    = aluSub;
            control.sizeSel  = sizeException;
            case (cause)
                causeInvalidOp: control.addrSelect = addrInvalidVec;
                causeOverflow:  control.addrSelect = addrOverflowVec;
                default:        control.addrSelect = addrNormal;
            endcase
        end
        else if (phase == phaseVector)
        begin
            control.pcWrite  = 1'b1;
            control.pcSource = pcVector;
            control.sizeSel  = sizeException;
        end
        else
        begin
            case (state)
                stResetInit:
                begin
                    control.regWrite = 1'b1;  // Stack pointer init
                    control.regDest  = destStack;
                    control.memToReg = m2rStackInit;
                end
                stFetchLoad:
                begin
                    control.irWrite = 1'b1;
                    control.aluSrcB = srcBFour;
                    control.aluOp   = aluAddOvf;
                end
                stDecode: control.pcWrite = 1'b1;
                stExecute:
                begin
                    control.aluSrcA = srcARegA;
                    control.aluSrcB = (decoded.instrClass == clsAluReg) ? srcBRegB : srcBImmediate;
                    control.aluOp   = decoded.aluOp;
                end
                stWriteRd, stWriteRt:
                begin
                    control.regWrite = 1'b1;
                    control.regDest  = (state == stWriteRd) ? destRd : destRt;
                end
                stBranchTarget:
                begin
                    control.aluSrcB = srcBBranchOffset;
                    control.aluOp   = aluAddOvf;
                end
                stBranchCompare:
                begin
                    control.pcWriteCond = 1'b1;
                    control.aluSrcA     = srcARegA;
                    control.aluOp       = decoded.aluOp;  // Equal or not equal
                end
                stBranchCommit: control.aluSrcA = srcARegA;
                stMemAddr, stStoreWrite:
                begin
                    control.aluSrcA  = srcARegA;
                    control.aluSrcB  = srcBImmediate;
                    control.aluOp    = aluAddOvf;
                    control.iorD     = (state == stStoreWrite);
                    control.memWrite = (state == stStoreWrite);
                end
                stMemRead: control.iorD = 1'b1;
                stLoadWrite:
                begin
                    control.iorD     = 1'b1;
                    control.regWrite = 1'b1;
                    control.memToReg = m2rMemory;
                end
                stJump, stJal:
                begin
                    control.pcWrite  = 1'b1;
                    control.pcSource = pcJumpTarget;
                    control.regWrite = (state == stJal);  // Link into ra
                    control.regDest  = (state == stJal) ? destRa : destRt;
                    control.memToReg = (state == stJal) ? m2rReturnAddr : m2rAlu;
                end
                default: control.aluOp = aluPass;
            endcase
        end
    end

endmodule

// File: design/exceptionMonitor.sv
`timescale 1ns/1ps

module exceptionMonitor import controlPkg::*;
#(
    parameter int FaultHold  = 6,
    parameter int VectorHold = 2
)
(
    input  logic       clk,
    input  logic       reset,
    input  decodeT     decoded,
    input  seqStatusT  seqStatus,
    input  logic       overflowFlag,
    output faultPhaseT phase,
    output faultCauseT cause
);

    localparam int HoldMax    = (FaultHold > VectorHold) ? FaultHold : VectorHold;
    localparam int CountWidth = $clog2(HoldMax + 1);

    logic                  overflowHit;
    logic                  invalidHit;
    logic [CountWidth-1:0] holdCount;

    assign overflowHit = seqStatus.overflowWatch && overflowFlag;
    assign invalidHit  = seqStatus.decodeNow && (decoded.instrClass == clsInvalid);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase     <= phaseIdle;
            cause     <= causeNone;
            holdCount <= '0;
        end
        else
        begin
            case (phase)
                phaseIdle:
                begin
                    if (overflowHit || invalidHit)
                    begin
                        phase     <= phaseSaveEpc;
                        cause     <= overflowHit ? causeOverflow : causeInvalidOp;  // Overflow first
                        holdCount <= CountWidth'(FaultHold - 1);
                    end
                end
                phaseSaveEpc:
                begin
                    if (holdCount == '0)
                    begin
                        phase     <= phaseVector;
                        holdCount <= CountWidth'(VectorHold - 1);
                    end
                    else
                        holdCount <= holdCount - 1'b1;
                end
                phaseVector:
                begin
                    if (holdCount == '0)
                    begin
                        phase <= phaseIdle;
                        cause <= causeNone;  // Cleared with the return to idle
                    end
                    else
                        holdCount <= holdCount - 1'b1;
                end
                default: phase <= phaseIdle;
            endcase
        end
    end

endmodule

// File: design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import controlPkg::*;
(
    input  fieldT  opcode,
    input  fieldT  funct,
    output decodeT decoded
);

    always_comb
    begin
        decoded.instrClass = clsInvalid;  // Anything unlisted traps
        decoded.aluOp      = aluPass;

        case (opcode)
            opRType:
            begin
                decoded.instrClass = clsAluReg;
                case (funct)
                    functAdd: decoded.aluOp = aluAddOvf;
                    functSub: decoded.aluOp = aluSub;
                    functAnd: decoded.aluOp = aluAnd;
                    functOr:  decoded.aluOp = aluOr;
                    functSlt: decoded.aluOp = aluCmp;
                    default:
                    begin
                        decoded.instrClass = clsInvalid;  // Shifts, mult, div are gone
                        decoded.aluOp      = aluPass;
                    end
                endcase
            end
            opAddi:
            begin
                decoded.instrClass = clsAluImm;
                decoded.aluOp      = aluAddOvf;
            end
            opAddiu:
            begin
                decoded.instrClass = clsAluImm;
                decoded.aluOp      = aluAddNoOvf;  // Never raises overflow
            end
            opSlti:
            begin
                decoded.instrClass = clsAluImm;
                decoded.aluOp      = aluCmp;
            end
            opBeq:
            begin
                decoded.instrClass = clsBranch;
                decoded.aluOp      = aluEq;
            end
            opBne:
            begin
                decoded.instrClass = clsBranch;
                decoded.aluOp      = aluNe;
            end
            opLw:
            begin
                decoded.instrClass = clsLoad;
                decoded.aluOp      = aluAddOvf;  // Address calculation
            end
            opSw:
            begin
                decoded.instrClass = clsStore;
                decoded.aluOp      = aluAddOvf;
            end
            opJ:   decoded.instrClass = clsJump;
            opJal: decoded.instrClass = clsJal;
            default: decoded.instrClass = clsInvalid;
        endcase
    end

endmodule

// File: design/mipsControl.sv
`timescale 1ns/1ps

module mipsControl import controlPkg::*;
#(
    parameter int FetchWait  = 2,
    parameter int FaultHold  = 6,
    parameter int VectorHold = 2
)
(
    input  logic        clk,
    input  logic        reset,
    input  fieldT       opcode,
    input  fieldT       funct,
    input  logic        overflowFlag,
    output controlWordT control,
    output faultCauseT  cause
);

    decodeT     decoded;
    seqStatusT  seqStatus;
    faultPhaseT phase;

    instrDecoder i_instrDecoder (
        .opcode  (opcode),
        .funct   (funct),
        .decoded (decoded)
    );

    exceptionMonitor #(
        .FaultHold  (FaultHold),
        .VectorHold (VectorHold)
    ) i_exceptionMonitor (
        .clk          (clk),
        .reset        (reset),
        .decoded      (decoded),
        .seqStatus    (seqStatus),
        .overflowFlag (overflowFlag),
        .phase        (phase),
        .cause        (cause)
    );

    controlSequencer #(
        .FetchWait (FetchWait)
    ) i_controlSequencer (
        .clk       (clk),
        .reset     (reset),
        .decoded   (decoded),
        .phase     (phase),
        .cause     (cause),
        .seqStatus (seqStatus),
        .control   (control)
    );

endmodule

// File: flist.f
+incdir+tests
design/controlPkg.sv
design/instrDecoder.sv
design/exceptionMonitor.sv
design/controlSequencer.sv
design/mipsControl.sv
tests/tbMipsControl.sv

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tbMipsControl \
    -Mdir obj_dir -f flist.f

./obj_dir/VtbMipsControl > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
    echo "RESULT: PASS"
    exit 0
fi
echo "RESULT: FAIL (pass line not found in sim.log)"
exit 1

// File: tests/controlChecks.svh
typedef struct packed {
    logic [6:0] strobes;  // pcWrite pcWriteCond iorD memWrite irWrite epcWrite regWrite
    regDestT    dest;     // Checked only with regWrite
    memToRegT   m2r;
    pcSourceT   pcSrc;    // pcAluOut here means not checked
    aluOpT      op;       // aluPass here means no ALU operation or operand check
    aluSrcBT    srcB;
    faultCauseT why;
    logic       ovf;      // overflowFlag level driven in this cycle
} stepT;

localparam logic [6:0] sNone  = 7'b0000000;
localparam logic [6:0] sRw    = 7'b0000001;
localparam logic [6:0] sEpc   = 7'b0000010;
localparam logic [6:0] sIr    = 7'b0000100;
localparam logic [6:0] sIord  = 7'b0010000;
localparam logic [6:0] sStore = 7'b0011000;
localparam logic [6:0] sLoad  = 7'b0010001;
localparam logic [6:0] sCond  = 7'b0100000;
localparam logic [6:0] sPc    = 7'b1000000;
localparam logic [6:0] sJal   = 7'b1000001;

// Kinds 14 and 15 use unlisted codes while 16 and 17 are an overflowing add and addi
localparam int NumKinds = 18;
localparam fieldT kindOp [NumKinds] = '{opRType, opRType, opRType, opRType, opRType,
    opAddi, opAddiu, opSlti, opBeq, opBne, opLw, opSw, opJ, opJal, 6'h0f, opRType,
    opRType, opAddi};
localparam fieldT kindFn [NumKinds] = '{functAdd, functSub, functAnd, functOr, functSlt,
    6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h18,
    functAdd, 6'h00};
localparam aluOpT kindAlu [NumKinds] = '{aluAddOvf, aluSub, aluAnd, aluOr, aluCmp,
    aluAddOvf, aluAddNoOvf, aluCmp, aluEq, aluNe, aluPass, aluPass, aluPass, aluPass,
    aluPass, aluPass, aluAddOvf, aluAddOvf};

stepT       steps[$];
faultCauseT faultCause = causeNone;

task automatic expectField(string what, logic [7:0] got, logic [7:0] exp);
    assert (got === exp)
    else stopOnError($sformatf("Mismatch at %0t: %s is %0h, expected %0h",
                               $time, what, got, exp));
endtask

task automatic checkStep(stepT e);
    logic [6:0] strobes;
    strobes = {control.pcWrite, control.pcWriteCond, control.iorD, control.memWrite,
               control.irWrite, control.epcWrite, control.regWrite};
    expectField("strobes", 8'(strobes), 8'(e.strobes));
    expectField("cause", 8'(cause), 8'(e.why));
    expectField("sizeSel", 8'(control.sizeSel),
                (e.why != causeNone) ? 8'(sizeException) : 8'(sizeWord));
    if (e.strobes[0])
    begin
        expectField("regDest", 8'(control.regDest), 8'(e.dest));
        expectField("memToReg", 8'(control.memToReg), 8'(e.m2r));
    end
    if (e.pcSrc != pcAluOut)
        expectField("pcSource", 8'(control.pcSource), 8'(e.pcSrc));
    if (e.op != aluPass)
    begin
        expectField("aluOp", 8'(control.aluOp), 8'(e.op));
        expectField("aluSrcB", 8'(control.aluSrcB), 8'(e.srcB));
        expectField("aluSrcA", 8'(control.aluSrcA),
                    (e.srcB == srcBFour) ? 8'(srcAPc) : 8'(srcARegA));  // PC steps by four
    end
    if (e.strobes[1])
        expectField("addrSelect", 8'(control.addrSelect),
                    (e.why == causeOverflow) ? 8'(addrOverflowVec) : 8'(addrInvalidVec));
endtask

function automatic stepT mkStep(logic [6:0] strobes, regDestT dest, memToRegT m2r,
                                pcSourceT pcSrc, aluOpT op, aluSrcBT srcB, logic ovf);
    faultCauseT why;
    why = (strobes[1] || pcSrc == pcVector) ? faultCause : causeNone;  // Fault cycles only
    return '{strobes, dest, m2r, pcSrc, op, srcB, why, ovf};
endfunction

task automatic addStep(int n, logic [6:0] strobes, regDestT dest, memToRegT m2r,
                       pcSourceT pcSrc, aluOpT op, aluSrcBT srcB, logic ovf);
    repeat (n)
        steps.push_back(mkStep(strobes, dest, m2r, pcSrc, op, srcB, ovf));
endtask

task automatic addFaultSteps(faultCauseT why);
    faultCause = why;
    addStep(FaultHold, sEpc, destRt, m2rAlu, pcAluOut, aluSub, srcBFour, 1'b0);
    addStep(VectorHold, sPc, destRt, m2rAlu, pcVector, aluPass, srcBRegB, 1'b0);
endtask

task automatic buildSteps(logic [4:0] kind, logic fetchOvf);
    aluOpT   op;
    aluSrcBT srcB;
    op   = kindAlu[kind];
    srcB = (kind < 5 || kind == 16) ? srcBRegB : srcBImmediate;  // Register group uses rt
    steps.delete();
    faultCause = causeNone;
    addStep(FetchWait, sNone, destRt, m2rAlu, pcAluOut, aluPass, srcBRegB, fetchOvf);
    addStep(1, sIr, destRt, m2rAlu, pcAluOut, aluAddOvf, srcBFour, 1'b0);
    addStep(1, sPc, destRt, m2rAlu, pcAluOut, aluPass, srcBRegB, 1'b0);  // Decode
    case (kind)
        0, 1, 2, 3, 4, 5, 6, 7:
        begin
            addStep(1, sNone, destRt, m2rAlu, pcAluOut, op, srcB, 1'b0);
            addStep(1, sRw, (kind < 5) ? destRd : destRt, m2rAlu, pcAluOut, aluPass,
                    srcBRegB, 1'b0);
        end
        8, 9:
        begin
            addStep(1, sNone, destRt, m2rAlu, pcAluOut, aluPass, srcBRegB, 1'b0);
            addStep(1, sCond, destRt, m2rAlu, pcAluOut, op, srcBRegB, 1'b0);
            addStep(1, sNone, destRt, m2rAlu, pcAluOut, aluPass, srcBRegB, 1'b0);
        end
        10:
        begin
            addStep(1, sNone, destRt, m2rAlu, pcAluOut, aluPass, srcBRegB, 1'b0);
            addStep(2, sIord, destRt, m2rAlu, pcAluOut, aluPass, srcBRegB, 1'b0);
            addStep(2, sLoad, destRt, m2rMemory, pcAluOut, aluPass, srcBRegB, 1'b0);
        end
        11:
        begin
            addStep(1, sNone, destRt, m2rAlu, pcAluOut, aluPass, srcBRegB, 1'b0);
            addStep(1, sStore, destRt, m2rAlu, pcAluOut, aluPass, srcBRegB, 1'b0);
        end
        12: addStep(1, sPc, destRt, m2rAlu, pcJumpTarget, aluPass, srcBRegB, 1'b0);
        13: addStep(2, sJal, destRa, m2rReturnAddr, pcJumpTarget, aluPass, srcBRegB, 1'b0);
        14, 15: addFaultSteps(causeInvalidOp);  // Trap right after decode
        default:
        begin
            addStep(1, sNone, destRt, m2rAlu, pcAluOut, op, srcB, 1'b1);
            addFaultSteps(causeOverflow);
        end
    endcase
endtask

// File: tests/tbMipsControl.sv
`timescale 1ns/1ps

module tbMipsControl import controlPkg::*;
();

    localparam int FetchWait  = 2;
    localparam int FaultHold  = 6;
    localparam int VectorHold = 2;
    localparam int NumInstr   = 60;
    localparam int LongestSeq = FetchWait + 3 + FaultHold + VectorHold;  // Overflow trap
    localparam int WatchdogNs = (NumInstr * LongestSeq + 20) * 10;

    logic        clk;
    logic        reset;
    fieldT       opcode;
    fieldT       funct;
    logic        overflowFlag;
    controlWordT control;
    faultCauseT  cause;
    int          seed;

    task automatic stopOnError(string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "Testbench stopped at the first error");
    endtask

    `include "controlChecks.svh"

    mipsControl #(
        .FetchWait  (FetchWait),
        .FaultHold  (FaultHold),
        .VectorHold (VectorHold)
    ) i_mipsControl (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .funct        (funct),
        .overflowFlag (overflowFlag),
        .control      (control),
        .cause        (cause)
    );

    always #5 clk = ~clk;

    initial
    begin
        #(WatchdogNs);
        stopOnError("Watchdog timeout: the instruction sequence did not finish in time");
    end

    initial
    begin
        logic [4:0] kind;
        clk          = 1'b0;
        reset        = 1'b1;
        opcode       = opRType;
        funct        = functAdd;
        overflowFlag = 1'b0;
        seed         = 34464;

        repeat (8) @(negedge clk);
        checkStep(mkStep(sRw, destStack, m2rStackInit, pcAluOut, aluPass, srcBRegB, 1'b0));
        reset = 1'b0;
        @(negedge clk);
        checkStep(mkStep(sRw, destStack, m2rStackInit, pcAluOut, aluPass, srcBRegB, 1'b0));

        // Every kind once in order, then random picks
        for (int i = 0; i < NumInstr; i++)
        begin
            kind = (i < NumKinds) ? 5'(i) : 5'($unsigned($random(seed)) % NumKinds);
            buildSteps(kind, 1'($random(seed)));
            foreach (steps[k])
            begin
                @(negedge clk);
                checkStep(steps[k]);
                if (k == 0)
                begin
                    opcode = kindOp[kind];  // Held until the next fetch
                    funct  = kindFn[kind];
                end
                overflowFlag = steps[k].ovf;
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule
